//--- design/blur_pkg.sv
package blur_pkg;

  // Image geometry
  localparam int PIX_W     = 8;
  localparam int STRIP_PIX = 16;
  localparam int IMG_W     = 64;
  localparam int IMG_H     = 16;
  localparam int N_STRIPS  = IMG_W / STRIP_PIX;

  // Strip plus one halo pixel on each side
  localparam int WIN_PIX   = STRIP_PIX + 2;

  // Index widths
  localparam int ROW_W     = $clog2(IMG_H);
  localparam int STRIP_W   = $clog2(N_STRIPS);

  typedef logic [PIX_W-1:0] pixel_t;

  // Pixel 0 sits in the low bits
  typedef pixel_t [IMG_W-1:0] img_row_t;

  typedef pixel_t [STRIP_PIX-1:0] strip_row_t;

  typedef pixel_t [WIN_PIX-1:0] win_row_t;

  typedef logic [ROW_W-1:0] row_idx_t;

  typedef logic [STRIP_W-1:0] strip_idx_t;

  // Frame sequencer
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_SWEEP = 2'd1,
    ST_FLUSH = 2'd2,
    ST_DONE  = 2'd3
  } strip_state_e;

endpackage

//--- design/row_step_if.sv
`timescale 1ns/100ps

interface row_step_if import blur_pkg::*; ();

  logic       shift;
  logic       pad;
  logic       clear;
  strip_idx_t strip;
  logic       emit;
  row_idx_t   out_row;

  modport seq (
    output shift, pad, clear, strip, emit, out_row
  );

  // Window loads rows
  modport win (
    input shift, pad, clear, strip
  );

  // Kernel writes finished rows
  modport kern (
    input emit, out_row, strip
  );

endinterface

//--- design/strip_sequencer.sv
`timescale 1ns/100ps

module strip_sequencer import blur_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     start,
  output logic     done,
  output row_idx_t img_addr,
  row_step_if.seq  step
);

  strip_state_e state;
  strip_idx_t   strip_cnt;
  row_idx_t     out_row;
  logic         rd_valid;
  logic         pad;
  logic         clear;
  logic         shift;
  logic         primed;
  logic         emit;
  logic         wr_last;
  logic         frame_go;
  logic         last_row;
  logic         last_strip;
  logic         last_emit;

  assign frame_go   = (state == ST_IDLE) && start;
  assign last_row   = (img_addr == row_idx_t'(IMG_H - 1));
  assign last_strip = (strip_cnt == strip_idx_t'(N_STRIPS - 1));
  assign last_emit  = emit && (out_row == row_idx_t'(IMG_H - 1)) && last_strip;

  // Read data arrives one cycle after the address, pad row follows the last one
  assign shift = rd_valid || pad;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_SWEEP;
          end
        end
        ST_SWEEP: begin
          if (last_row) begin
            state <= ST_FLUSH;
          end
        end
        // Two cycles here: last real row, then the zero row
        ST_FLUSH: begin
          if (pad) begin
            state <= last_strip ? ST_DONE : ST_SWEEP;
          end
        end
        ST_DONE: begin
          if (wr_last) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      img_addr <= '0;
    end else if (state == ST_SWEEP && !last_row) begin
      img_addr <= img_addr + 1'b1;
    end else begin
      img_addr <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
      pad      <= 1'b0;
      clear    <= 1'b0;
      primed   <= 1'b0;
      emit     <= 1'b0;
    end else begin
      rd_valid <= (state == ST_SWEEP);
      pad      <= (state == ST_FLUSH) && rd_valid;
      clear    <= frame_go || ((state == ST_FLUSH) && pad && !last_strip);
      // First row of a strip leaves the window without a centre
      if (clear) begin
        primed <= 1'b0;
      end else if (shift) begin
        primed <= 1'b1;
      end
      emit <= shift && primed;
    end
  end

  // Strip advances only after its last centre row has gone out
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_row   <= '0;
      strip_cnt <= '0;
    end else if (frame_go) begin
      out_row   <= '0;
      strip_cnt <= '0;
    end else if (emit) begin
      out_row <= out_row + 1'b1;
      if (out_row == row_idx_t'(IMG_H - 1)) begin
        strip_cnt <= strip_cnt + 1'b1;
      end
    end
  end

  // wr_last lines up with the final blur write
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_last <= 1'b0;
      done    <= 1'b0;
    end else begin
      wr_last <= last_emit;
      if (frame_go) begin
        done <= 1'b0;
      end else if (wr_last) begin
        done <= 1'b1;
      end
    end
  end

  assign step.shift   = shift;
  assign step.pad     = pad;
  assign step.clear   = clear;
  assign step.strip   = strip_cnt;
  assign step.emit    = emit;
  assign step.out_row = out_row;

endmodule

//--- design/line_window.sv
`timescale 1ns/100ps

module line_window import blur_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  img_row_t img_dout,
  row_step_if.win  step,
  output win_row_t top,
  output win_row_t mid,
  output win_row_t bot
);

  // Index k holds image column k-1, zero beyond both edges
  pixel_t [IMG_W+1:0] padded;
  win_row_t           slice;
  win_row_t           incoming;

  assign padded = {pixel_t'(0), img_dout, pixel_t'(0)};

  // Columns 16*strip-1 up to 16*strip+16
  assign slice = padded[step.strip * STRIP_PIX +: WIN_PIX];

  // Zero row below the last image row
  assign incoming = step.pad ? win_row_t'(0) : slice;

  always_ff @(posedge clk) begin
    if (!rst_n || step.clear) begin
      // Zero row above row 0 of the strip
      top <= '0;
      mid <= '0;
      bot <= '0;
    end else if (step.shift) begin
      top <= mid;
      mid <= bot;
      bot <= incoming;
    end
  end

endmodule

//--- design/gauss3_strip.sv
`timescale 1ns/100ps

module gauss3_strip import blur_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  win_row_t   top,
  input  win_row_t   mid,
  input  win_row_t   bot,
  row_step_if.kern   step,
  output logic       blur_we,
  output row_idx_t   blur_row,
  output strip_idx_t blur_strip,
  output strip_row_t blur_din
);

  strip_row_t lane;

  // Horizontal 1 2 1 taps around window column i+1
  function automatic logic [9:0] taps121(input win_row_t r, input int i);
    return {2'b00, r[i]} + {1'b0, r[i+1], 1'b0} + {2'b00, r[i+2]};
  endfunction

  // Max sum 255*16+8 fits 12 bits
  function automatic pixel_t blur_pix(input win_row_t t, input win_row_t m,
                                      input win_row_t b, input int i);
    logic [11:0] acc;
    acc = {2'b00, taps121(t, i)} + {1'b0, taps121(m, i), 1'b0}
        + {2'b00, taps121(b, i)} + 12'd8;
    return acc[11:4];
  endfunction

  always_comb begin
    for (int i = 0; i < STRIP_PIX; i++) begin
      lane[i] = blur_pix(top, mid, bot, i);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur_we <= 1'b0;
    end else begin
      blur_we <= step.emit;
    end
  end

  // Result row with its place in the blur memory
  always_ff @(posedge clk) begin
    if (step.emit) begin
      blur_din   <= lane;
      blur_row   <= step.out_row;
      blur_strip <= step.strip;
    end
  end

endmodule

//--- design/blur_top.sv
`timescale 1ns/100ps

module blur_top import blur_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  output logic       done,
  output row_idx_t   img_addr,
  input  img_row_t   img_dout,
  output logic       blur_we,
  output row_idx_t   blur_row,
  output strip_idx_t blur_strip,
  output strip_row_t blur_din
);

  win_row_t win_top;
  win_row_t win_mid;
  win_row_t win_bot;

  row_step_if step ();

  strip_sequencer u_seq (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .done     (done),
    .img_addr (img_addr),
    .step     (step.seq)
  );

  // Three rows of the current strip
  line_window u_win (
    .clk      (clk),
    .rst_n    (rst_n),
    .img_dout (img_dout),
    .step     (step.win),
    .top      (win_top),
    .mid      (win_mid),
    .bot      (win_bot)
  );

  gauss3_strip u_kern (
    .clk        (clk),
    .rst_n      (rst_n),
    .top        (win_top),
    .mid        (win_mid),
    .bot        (win_bot),
    .step       (step.kern),
    .blur_we    (blur_we),
    .blur_row   (blur_row),
    .blur_strip (blur_strip),
    .blur_din   (blur_din)
  );

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
  output logic clk,
  output logic rst_n
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

//--- sim/tb_blur.sv
`timescale 1ns/100ps

module tb_blur import blur_pkg::*; ();

  localparam logic [31:0] SEED = 32'he1be_a298;
  localparam int FRAMES           = 4;
  localparam int CLK_NS           = 20;
  localparam int MARGIN_CYCLES    = 200;
  localparam int WRITES_PER_FRAME = N_STRIPS * IMG_H;

  logic        clk;
  logic        rst_n;
  logic        start;
  logic        done;
  row_idx_t    img_addr;
  img_row_t    img_dout;
  logic        blur_we;
  row_idx_t    blur_row;
  strip_idx_t  blur_strip;
  strip_row_t  blur_din;

  img_row_t    image_mem [IMG_H];
  row_idx_t    addr_q;
  logic [31:0] lfsr;
  logic        running;
  logic        flat_frame;
  logic        done_due;
  logic        done_held;
  int          writes;
  int          exp_strip;
  int          exp_row;

  tb_clock u_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  blur_top i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .done       (done),
    .img_addr   (img_addr),
    .img_dout   (img_dout),
    .blur_we    (blur_we),
    .blur_row   (blur_row),
    .blur_strip (blur_strip),
    .blur_din   (blur_din)
  );

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_pixel(output pixel_t p);
    p = '0;
    for (int b = 0; b < PIX_W; b++) begin
      lfsr = lfsr_step(lfsr);
      p = {p[PIX_W-2:0], lfsr[0]};
    end
  endtask

  task automatic fill_image(input logic flat);
    pixel_t p;
    for (int r = 0; r < IMG_H; r++) begin
      for (int c = 0; c < IMG_W; c++) begin
        if (flat) begin
          p = 8'hff;
        end else begin
          draw_pixel(p);
        end
        image_mem[r][c] = p;
      end
    end
  endtask

  task automatic check_equal(input logic [127:0] actual, input logic [127:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  // Zero outside the image
  function automatic int pix_at(input int r, input int c);
    if (r < 0 || r >= IMG_H || c < 0 || c >= IMG_W) begin
      return 0;
    end
    return image_mem[r][c];
  endfunction

  function automatic pixel_t ref_pixel(input int r, input int c);
    int acc;
    int w;
    acc = 8;
    for (int dr = -1; dr <= 1; dr++) begin
      for (int dc = -1; dc <= 1; dc++) begin
        w = (dr == 0 ? 2 : 1) * (dc == 0 ? 2 : 1);
        acc += w * pix_at(r + dr, c + dc);
      end
    end
    return pixel_t'(acc / 16);
  endfunction

  function automatic strip_row_t ref_strip_row(input int s, input int r);
    strip_row_t row;
    for (int i = 0; i < STRIP_PIX; i++) begin
      row[i] = ref_pixel(r, s * STRIP_PIX + i);
    end
    return row;
  endfunction

  // Only kernel weight inside the border counts for an all-255 image
  function automatic pixel_t flat_expect(input int r, input int c);
    int vw;
    int hw;
    vw = 4;
    hw = 4;
    if (r == 0 || r == IMG_H - 1) begin
      vw = 3;
    end
    if (c == 0 || c == IMG_W - 1) begin
      hw = 3;
    end
    return pixel_t'((255 * vw * hw + 8) / 16);
  endfunction

  task automatic check_write();
    strip_row_t expected;
    check_equal(running, 1'b1, "blur write outside a frame");
    check_equal(blur_strip, exp_strip, "strip order");
    check_equal(blur_row, exp_row, "row order");
    expected = ref_strip_row(exp_strip, exp_row);
    check_equal(blur_din, expected, "blurred strip row");
    if (flat_frame) begin
      for (int i = 0; i < STRIP_PIX; i++) begin
        check_equal(blur_din[i], flat_expect(exp_row, exp_strip * STRIP_PIX + i),
                    "all-255 frame pixel");
      end
    end
    writes++;
    exp_row++;
    if (exp_row == IMG_H) begin
      exp_row = 0;
      exp_strip++;
    end
    if (writes == WRITES_PER_FRAME) begin
      done_due = 1'b1;
    end
  endtask

  // Synchronous image memory
  always @(negedge clk) begin
    addr_q = img_addr;
  end

  always @(posedge clk) begin
    #1;
    img_dout = image_mem[addr_q];
  end

  // Output monitor sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n) begin
      check_equal($isunknown(img_addr), 1'b0, "image row address has unknown bits");
      if (done_due) begin
        check_equal(done, 1'b1, "done one cycle after last write");
        done_due  = 1'b0;
        running   = 1'b0;
        done_held = 1'b1;
      end else if (running) begin
        check_equal(done, 1'b0, "done while frame running");
      end else if (done_held) begin
        check_equal(done, 1'b1, "done held until next start");
      end
      if (blur_we) begin
        check_write();
      end
    end
  end

  task automatic run_frame(input logic flat, input logic poke_start);
    @(posedge clk);
    #1;
    start = 1'b1;
    @(posedge clk);
    #1;
    start      = 1'b0;
    flat_frame = flat;
    writes     = 0;
    exp_strip  = 0;
    exp_row    = 0;
    done_held  = 1'b0;
    running    = 1'b1;
    check_equal(done, 1'b0, "done cleared by start");
    // A start mid-frame must be ignored
    if (poke_start) begin
      repeat (20) @(posedge clk);
      #1;
      start = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
    end
    wait (done === 1'b1);
    @(negedge clk);
    #1;
    check_equal(writes, WRITES_PER_FRAME, "writes per frame");
  endtask

  initial begin
    start      = 1'b0;
    img_dout   = '0;
    addr_q     = '0;
    lfsr       = SEED;
    running    = 1'b0;
    flat_frame = 1'b0;
    done_due   = 1'b0;
    done_held  = 1'b0;
    writes     = 0;
    exp_strip  = 0;
    exp_row    = 0;
    for (int r = 0; r < IMG_H; r++) begin
      image_mem[r] = '0;
    end
    wait (rst_n === 1'b1);
    repeat (3) begin
      @(negedge clk);
      check_equal(done, 1'b0, "done low after reset");
      check_equal(blur_we, 1'b0, "blur_we low after reset");
    end
    // Three random frames and then the all-255 frame
    for (int f = 0; f < FRAMES; f++) begin
      fill_image(f == FRAMES - 1);
      run_frame(f == FRAMES - 1, f == 1);
      repeat (5) @(posedge clk);
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

  initial begin
    #((FRAMES * N_STRIPS * (IMG_H + 4) + MARGIN_CYCLES) * CLK_NS);
    $display("Timeout: the frames did not finish in the expected number of cycles");
    $display("TESTBENCH FAILED");
    $fatal(1);
  end

endmodule

//--- verilog.f
design/blur_pkg.sv
design/row_step_if.sv
design/strip_sequencer.sv
design/line_window.sv
design/gauss3_strip.sv
design/blur_top.sv
sim/tb_clock.sv
sim/tb_blur.sv

//--- Bender.yml
package:
  name: gauss_blur

sources:
  - files:
      - design/blur_pkg.sv
      - design/row_step_if.sv
      - design/strip_sequencer.sv
      - design/line_window.sv
      - design/gauss3_strip.sv
      - design/blur_top.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/tb_blur.sv
